// ==== uart_word_pkg.sv ====
package uart_word_pkg;

	typedef logic [31:0] word_t; // One assembled word

	typedef struct packed {
		logic [7:0] data;  // Received byte
		logic       frame_err; // Stop bit sampled low
	} rx_byte_t;

	typedef struct packed {
		logic [3:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [3:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t; // Master to slave

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t; // Slave to master

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	localparam logic [3:0] REG_STATUS = 4'h0; // Read only
	localparam logic [3:0] REG_DATA   = 4'h4; // Pops FIFO on read
	localparam logic [3:0] REG_CTRL   = 4'h8; // Flag clears

	// Status word layout
	localparam int STAT_COUNT_LSB  = 0;
	localparam int STAT_COUNT_W    = 8;
	localparam int STAT_EMPTY      = 8;
	localparam int STAT_FULL       = 9;
	localparam int STAT_OVF        = 10;
	localparam int STAT_ERRCNT_LSB = 16;
	localparam int STAT_ERRCNT_W   = 8;

	localparam int CTRL_CLR_OVF = 0; // Clears sticky overflow
	localparam int CTRL_CLR_ERR = 1; // Clears framing-error count

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import uart_word_pkg::*; #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     rx,
	output logic     byte_valid,
	output rx_byte_t byte_out,
	output logic     busy
);
	localparam int HALF = CLKS_PER_BIT / 2;
	localparam int CW   = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	typedef enum logic [2:0] {
		S_IDLE,  // Line idle, waiting for edge
		S_START, // Recheck start bit at half period
		S_DATA,  // Eight data bits
		S_STOP,  // Stop bit sample
		S_TAIL   // Rest of stop bit
	} state_t;

	state_t        state;
	logic          rx_meta; // Synchronizer stage 1
	logic          rx_sync; // Synchronizer stage 2
	logic          rx_prev; // For edge detect
	logic [CW-1:0] clk_cnt;
	logic [2:0]    bit_idx;
	logic [7:0]    shift;
	logic          start_edge;
	logic          bit_mid;
	logic          stop_tick;

	assign start_edge = rx_prev & ~rx_sync; // High to low on the line
	assign bit_mid    = (clk_cnt == CW'(CLKS_PER_BIT - 1)); // Centre of data/stop bit
	assign stop_tick  = (state == S_STOP) && bit_mid;
	assign busy       = (state != S_IDLE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1; // Line idles high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= S_IDLE;
			clk_cnt    <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= stop_tick; // One cycle after stop sample
			clk_cnt    <= clk_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (start_edge) state <= S_START;
				end
				S_START: begin
					if (clk_cnt == CW'(HALF - 1)) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? S_IDLE : S_DATA; // Glitch goes back to idle
					end
				end
				S_DATA: begin
					if (bit_mid) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= S_STOP;
					end
				end
				S_STOP: begin
					if (bit_mid) begin
						clk_cnt <= '0;
						state   <= S_TAIL;
					end
				end
				S_TAIL: begin
					if (start_edge) begin // Next frame started early
						clk_cnt <= '0;
						state   <= S_START;
					end else if (clk_cnt == CW'(HALF - 1)) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_DATA && bit_mid) shift <= {rx_sync, shift[7:1]}; // LSB first
		if (stop_tick) begin
			byte_out.data      <= shift;
			byte_out.frame_err <= ~rx_sync; // Stop bit must be high
		end
	end

endmodule

// ==== word_packer.sv ====
`timescale 1ns/1ps

module word_packer import uart_word_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     byte_valid,
	input  rx_byte_t byte_in,
	output logic     word_valid,
	output word_t    word,
	output logic     frame_err_pulse
);
	logic [1:0] byte_cnt; // Lane select
	logic       good_byte;
	logic       bad_byte;

	assign good_byte = byte_valid & ~byte_in.frame_err;
	assign bad_byte  = byte_valid & byte_in.frame_err;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			byte_cnt        <= '0;
			word_valid      <= 1'b0;
			frame_err_pulse <= 1'b0;
		end else begin
			word_valid      <= 1'b0;
			frame_err_pulse <= bad_byte;
			if (bad_byte) begin
				byte_cnt <= '0; // Partial word thrown away
			end else if (good_byte) begin
				byte_cnt <= byte_cnt + 1'b1; // Wraps to zero after fourth
				if (byte_cnt == 2'd3) word_valid <= 1'b1;
			end
		end
	end

	// First byte lands in 31:24, later bytes fill downward
	always_ff @(posedge clk) begin
		if (good_byte) begin
			case (byte_cnt)
				2'd0: word[31:24] <= byte_in.data;
				2'd1: word[23:16] <= byte_in.data;
				2'd2: word[15:8]  <= byte_in.data;
				default: word[7:0] <= byte_in.data;
			endcase
		end
	end

endmodule

// ==== word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo import uart_word_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            push,
	input  word_t                           din,
	input  logic                            pop,
	output word_t                           dout,
	output logic                            empty,
	output logic                            full,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count,
	output logic                            overflow
);
	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	word_t         mem [FIFO_DEPTH]; // Storage, no reset
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_push;
	logic          do_pop;

	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
		if (ptr == AW'(FIFO_DEPTH - 1)) return '0; // Wrap for any depth
		return ptr + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == CW'(FIFO_DEPTH));
	assign do_pop  = pop & ~empty;
	assign do_push = push & (~full | pop); // Full push ok with pop
	assign dout    = mem[rd_ptr]; // Head word

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= push & full & ~pop; // Dropped word
			if (do_push) wr_ptr <= ptr_next(wr_ptr);
			if (do_pop) rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= din;
	end

endmodule

// ==== axil_word_regs.sv ====
`timescale 1ns/1ps

module axil_word_regs import uart_word_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  axil_req_t                       axil_req,
	output axil_rsp_t                       axil_rsp,
	input  word_t                           fifo_word,
	input  logic                            fifo_empty,
	input  logic                            fifo_full,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
	input  logic                            fifo_overflow,
	input  logic                            frame_err_pulse,
	output logic                            pop
);
	logic                     awready_q; // Also drives wready
	logic                     bvalid_q;
	logic [1:0]               bresp_q;
	logic                     arready_q;
	logic                     rvalid_q;
	logic [1:0]               rresp_q;
	word_t                    rdata_q;
	logic                     ovf_flag; // Sticky overflow
	logic [STAT_ERRCNT_W-1:0] err_cnt; // Saturating
	word_t                    status_word;
	logic                     wr_hs;
	logic                     rd_hs;
	logic                     ctrl_wr;
	logic [1:0]               wr_resp;
	logic [1:0]               rd_resp;
	word_t                    rd_data;

	assign wr_hs   = awready_q & axil_req.awvalid & axil_req.wvalid;
	assign rd_hs   = arready_q & axil_req.arvalid;
	assign ctrl_wr = wr_hs && (axil_req.awaddr == REG_CTRL) && axil_req.wstrb[0]; // Byte 0 only
	assign wr_resp = (axil_req.awaddr == REG_CTRL) ? RESP_OKAY : RESP_SLVERR;
	assign pop     = rd_hs && (axil_req.araddr == REG_DATA) && !fifo_empty; // Same edge as handshake

	always_comb begin
		status_word = '0;
		status_word[STAT_COUNT_LSB +: STAT_COUNT_W]   = STAT_COUNT_W'(fifo_count);
		status_word[STAT_EMPTY]                       = fifo_empty;
		status_word[STAT_FULL]                        = fifo_full;
		status_word[STAT_OVF]                         = ovf_flag;
		status_word[STAT_ERRCNT_LSB +: STAT_ERRCNT_W] = err_cnt;
	end

	// Read decode
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (axil_req.araddr)
			REG_STATUS: rd_data = status_word;
			REG_DATA: begin
				if (fifo_empty) rd_resp = RESP_SLVERR; // Zero data, no pop
				else rd_data = fifo_word;
			end
			REG_CTRL: rd_data = '0; // Clear bits read back as zero
			default: rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			awready_q <= 1'b0;
			bvalid_q  <= 1'b0;
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end else begin
			// Write channel
			if (wr_hs) begin
				awready_q <= 1'b0; // One-cycle ready
				bvalid_q  <= 1'b1;
			end else if (!awready_q && axil_req.awvalid && axil_req.wvalid && !bvalid_q) begin
				awready_q <= 1'b1;
			end
			if (bvalid_q && axil_req.bready) bvalid_q <= 1'b0;
			// Read channel
			if (rd_hs) begin
				arready_q <= 1'b0;
				rvalid_q  <= 1'b1;
			end else if (!arready_q && axil_req.arvalid && !rvalid_q) begin
				arready_q <= 1'b1; // Only with no response pending
			end
			if (rvalid_q && axil_req.rready) rvalid_q <= 1'b0;
		end
	end

	// Response payload, held until ready
	always_ff @(posedge clk) begin
		if (wr_hs) bresp_q <= wr_resp;
		if (rd_hs) begin
			rdata_q <= rd_data;
			rresp_q <= rd_resp;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ovf_flag <= 1'b0;
			err_cnt  <= '0;
		end else begin
			if (fifo_overflow) ovf_flag <= 1'b1; // New drop wins over clear
			else if (ctrl_wr && axil_req.wdata[CTRL_CLR_OVF]) ovf_flag <= 1'b0;
			if (ctrl_wr && axil_req.wdata[CTRL_CLR_ERR]) err_cnt <= '0;
			else if (frame_err_pulse && err_cnt != '1) err_cnt <= err_cnt + 1'b1;
		end
	end

	always_comb begin
		axil_rsp.awready = awready_q;
		axil_rsp.wready  = awready_q; // Raised together with awready
		axil_rsp.bresp   = bresp_q;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.arready = arready_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
		axil_rsp.rvalid  = rvalid_q;
	end

endmodule

// ==== uart_word_top.sv ====
`timescale 1ns/1ps

module uart_word_top import uart_word_pkg::*; #(
	parameter int CLKS_PER_BIT = 8, // Serial bit period in clocks
	parameter int FIFO_DEPTH   = 4  // Words held for the host
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      rx,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	logic          byte_valid;
	rx_byte_t      byte_out;
	logic          word_valid;
	word_t         word;
	logic          frame_err_pulse;
	word_t         fifo_dout;
	logic          fifo_empty;
	logic          fifo_full;
	logic [CW-1:0] fifo_count;
	logic          fifo_overflow;
	logic          pop;

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) rx_i (
		.clk       (clk),
		.rst       (rst),
		.rx        (rx),
		.byte_valid(byte_valid),
		.byte_out  (byte_out),
		.busy      () // Not needed by the register map
	);

	word_packer packer_i (
		.clk            (clk),
		.rst            (rst),
		.byte_valid     (byte_valid),
		.byte_in        (byte_out),
		.word_valid     (word_valid),
		.word           (word),
		.frame_err_pulse(frame_err_pulse)
	);

	word_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fifo_i (
		.clk     (clk),
		.rst     (rst),
		.push    (word_valid),
		.din     (word),
		.pop     (pop),
		.dout    (fifo_dout),
		.empty   (fifo_empty),
		.full    (fifo_full),
		.count   (fifo_count),
		.overflow(fifo_overflow)
	);

	axil_word_regs #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) regs_i (
		.clk            (clk),
		.rst            (rst),
		.axil_req       (axil_req),
		.axil_rsp       (axil_rsp),
		.fifo_word      (fifo_dout),
		.fifo_empty     (fifo_empty),
		.fifo_full      (fifo_full),
		.fifo_count     (fifo_count),
		.fifo_overflow  (fifo_overflow),
		.frame_err_pulse(frame_err_pulse),
		.pop            (pop)
	);

endmodule

// ==== tb_uart_word_props.sv ====
`timescale 1ns/1ps

module tb_uart_word_props import uart_word_pkg::*; (
	input logic      clk,
	input logic      rst,
	input axil_req_t axil_req,
	input axil_rsp_t axil_rsp,
	input logic      word_valid
);
	int fail_count = 0; // Failed assertion tally

	aw_w_hold: assert property (@(posedge clk) disable iff (rst)
		(axil_req.awvalid || axil_req.wvalid) && !axil_rsp.awready |=>
		axil_req.awvalid && axil_req.wvalid && $stable(axil_req.awaddr)
		&& $stable(axil_req.wdata) && $stable(axil_req.wstrb))
		else begin
			$error("Write address or data changed before awready/wready");
			fail_count++;
		end

	ar_hold: assert property (@(posedge clk) disable iff (rst)
		axil_req.arvalid && !axil_rsp.arready |=> axil_req.arvalid && $stable(axil_req.araddr))
		else begin
			$error("arvalid dropped or araddr changed before arready");
			fail_count++;
		end

	r_hold: assert property (@(posedge clk) disable iff (rst)
		axil_rsp.rvalid && !axil_req.rready |=>
		axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
		else begin
			$error("Read response dropped or changed before rready");
			fail_count++;
		end

	b_hold: assert property (@(posedge clk) disable iff (rst)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
		else begin
			$error("Write response dropped or changed before bready");
			fail_count++;
		end

	// Both response valids come out of reset low
	reset_clear: assert property (@(posedge clk)
		$fell(rst) |-> !axil_rsp.rvalid && !axil_rsp.bvalid)
		else begin
			$error("rvalid or bvalid high after reset");
			fail_count++;
		end

	word_pulse: assert property (@(posedge clk) disable iff (rst)
		word_valid |=> !word_valid)
		else begin
			$error("word_valid high for two cycles");
			fail_count++;
		end

endmodule

bind uart_word_top tb_uart_word_props props_i (
	.clk       (clk),
	.rst       (rst),
	.axil_req  (axil_req),
	.axil_rsp  (axil_rsp),
	.word_valid(word_valid)
);

// ==== tb_uart_word.sv ====
`timescale 1ns/1ps

module tb_uart_word import uart_word_pkg::*; ();
	localparam int CLKS_PER_BIT = 8;
	localparam int FIFO_DEPTH   = 4;
	localparam int CLK_NS       = 4;
	localparam int MARGIN_NS    = 20000; // Register polling and draining
	localparam int HS_LIMIT     = 64; // Cycles allowed for a ready or valid

	logic      clk = 1'b0;
	logic      rst;
	logic      rx;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;

	string       row_name[$]; // Stimulus table columns
	logic [31:0] row_bytes[$]; // First byte in 31:24
	int          row_bad[$]; // Corrupted byte index, -1 for none
	int          row_words[$];
	bit          row_rnd[$]; // Fresh random bytes per word
	bit          row_clear[$]; // CTRL clear after draining

	word_t model_q[$]; // Expected FIFO contents
	word_t model_part;
	int    model_lane;
	bit    model_ovf;
	int    model_err;

	integer seed = 32'hda8;
	int     errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     test_errs = 0;
	int     frames = 0;
	int     prop_fails;
	bit     table_ready = 1'b0;
	longint limit_ns;

	uart_word_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.FIFO_DEPTH  (FIFO_DEPTH)
	) dut_i (
		.clk     (clk),
		.rst     (rst),
		.rx      (rx),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic add_row(input string name, input logic [31:0] bytes, input int bad,
			input int words, input bit rnd, input bit clear);
		row_name.push_back(name);
		row_bytes.push_back(bytes);
		row_bad.push_back(bad);
		row_words.push_back(words);
		row_rnd.push_back(rnd);
		row_clear.push_back(clear);
	endtask

	task automatic report_mismatch(input string name, input string what, input word_t exp,
			input word_t act);
		$display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
		errors++;
		test_errs++;
	endtask

	task automatic hs_timeout(input string what, input logic [3:0] addr);
		$display("No %s handshake within %0d cycles at offset %h", what, HS_LIMIT, addr);
		errors++;
		test_errs++;
	endtask

	// Start bit, 8 data bits LSB first, stop bit, one idle bit
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [10:0] frame;
		frame = {1'b1, stop_bit, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(negedge clk);
			rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(negedge clk);
		end
	endtask

	task automatic model_byte(input logic [7:0] data, input bit good);
		if (!good) begin
			model_lane = 0; // Partial word lost
			if (model_err < 255) model_err++;
		end else begin
			model_part[31 - 8 * model_lane -: 8] = data;
			model_lane++;
			if (model_lane == 4) begin
				model_lane = 0;
				if (model_q.size() < FIFO_DEPTH) model_q.push_back(model_part);
				else model_ovf = 1'b1; // Dropped on full
			end
		end
	endtask

	task automatic axi_read(input logic [3:0] addr, output word_t data, output logic [1:0] resp);
		int n;
		n = 0;
		@(negedge clk);
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b0; // Response held back one cycle
		do begin
			@(negedge clk);
			n++;
		end while (!axil_rsp.arready && n < HS_LIMIT);
		if (!axil_rsp.arready) hs_timeout("read address", addr);
		@(negedge clk); // Handshake edge has passed
		axil_req.arvalid = 1'b0;
		n = 0;
		while (!axil_rsp.rvalid && n < HS_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.rvalid) hs_timeout("read data", addr);
		@(negedge clk); // rvalid must hold without rready
		axil_req.rready = 1'b1;
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	task automatic axi_write(input logic [3:0] addr, input word_t data, output logic [1:0] resp);
		int n;
		n = 0;
		@(negedge clk);
		axil_req.awaddr  = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hf;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b0; // Response held back one cycle
		do begin
			@(negedge clk);
			n++;
		end while (!(axil_rsp.awready && axil_rsp.wready) && n < HS_LIMIT);
		if (!(axil_rsp.awready && axil_rsp.wready)) hs_timeout("write address and data", addr);
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		n = 0;
		while (!axil_rsp.bvalid && n < HS_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.bvalid) hs_timeout("write response", addr);
		@(negedge clk); // bvalid must hold without bready
		axil_req.bready = 1'b1;
		resp = axil_rsp.bresp;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	function automatic word_t expected_status();
		word_t s;
		s        = '0;
		s[7:0]   = 8'(model_q.size());
		s[8]     = (model_q.size() == 0);
		s[9]     = (model_q.size() == FIFO_DEPTH);
		s[10]    = model_ovf;
		s[23:16] = 8'(model_err);
		return s;
	endfunction

	// Poll until the status settles on the model, then compare
	task automatic check_status(input string name);
		word_t      exp;
		word_t      got;
		logic [1:0] resp;
		int         tries;
		exp   = expected_status();
		tries = 0;
		do begin
			axi_read(REG_STATUS, got, resp);
			tries++;
		end while (got !== exp && tries < 100);
		if (got !== exp) report_mismatch(name, "status", exp, got);
		if (resp !== RESP_OKAY) report_mismatch(name, "status resp", RESP_OKAY, resp);
	endtask

	task automatic run_row(input int r);
		word_t      bytes;
		word_t      got;
		logic [1:0] resp;
		bytes = row_bytes[r];
		for (int w = 0; w < row_words[r]; w++) begin
			if (row_rnd[r]) bytes = $random(seed);
			if (w == 0 && row_bad[r] >= 0) begin
				for (int b = 0; b <= row_bad[r]; b++) begin // Bad stop on the last one
					send_frame(bytes[31 - 8 * b -: 8], b != row_bad[r]);
					model_byte(bytes[31 - 8 * b -: 8], b != row_bad[r]);
				end
			end
			for (int b = 0; b < 4; b++) begin
				send_frame(bytes[31 - 8 * b -: 8], 1'b1);
				model_byte(bytes[31 - 8 * b -: 8], 1'b1);
			end
		end
		check_status(row_name[r]);
		while (model_q.size() > 0) begin
			axi_read(REG_DATA, got, resp);
			if (got !== model_q[0]) report_mismatch(row_name[r], "data", model_q[0], got);
			if (resp !== RESP_OKAY) report_mismatch(row_name[r], "data resp", RESP_OKAY, resp);
			void'(model_q.pop_front());
		end
		check_status(row_name[r]); // Empty, sticky flags kept
		if (row_clear[r]) begin
			axi_write(REG_CTRL, 32'h3, resp);
			if (resp !== RESP_OKAY) report_mismatch(row_name[r], "ctrl resp", RESP_OKAY, resp);
			model_ovf = 1'b0;
			model_err = 0;
			check_status(row_name[r]);
		end
	endtask

	task automatic slverr_checks(input string name);
		word_t      got;
		logic [1:0] resp;
		axi_read(REG_DATA, got, resp); // FIFO empty here
		if (resp !== RESP_SLVERR) report_mismatch(name, "empty read resp", RESP_SLVERR, resp);
		if (got !== '0) report_mismatch(name, "empty read data", '0, got);
		axi_write(REG_DATA, 32'h12345678, resp);
		if (resp !== RESP_SLVERR) report_mismatch(name, "data write resp", RESP_SLVERR, resp);
		axi_read(4'hc, got, resp); // Unused offset
		if (resp !== RESP_SLVERR) report_mismatch(name, "unused read resp", RESP_SLVERR, resp);
		check_status(name);
	endtask

	task automatic print_result(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("Test %s done, no errors", name);
		end else begin
			$display("Test %s done, %0d errors", name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	initial begin
		wait (table_ready);
		#(limit_ns);
		$display("Watchdog expired after %0d ns, tests did not finish", limit_ns);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		rst        = 1'b1;
		rx         = 1'b1; // Line idles high
		axil_req   = '0;
		model_part = '0;
		model_lane = 0;
		model_ovf  = 1'b0;
		model_err  = 0;
		add_row("single_word", 32'h11223344, -1, 1, 1'b0, 1'b0);
		add_row("words_in_order", 32'h0, -1, 3, 1'b1, 1'b0);
		add_row("bad_stop_third_byte", 32'ha1b2c3d4, 2, 1, 1'b0, 1'b0);
		add_row("bad_stop_first_byte", 32'h0, 0, 2, 1'b1, 1'b0);
		add_row("overflow_and_clear", 32'h0, -1, FIFO_DEPTH + 1, 1'b1, 1'b1);
		add_row("fill_to_full", 32'h5aa5c33c, -1, FIFO_DEPTH, 1'b0, 1'b0);
		foreach (row_words[r]) begin
			frames += row_words[r] * 4 + ((row_bad[r] >= 0) ? row_bad[r] + 1 : 0);
		end
		limit_ns    = longint'(frames) * 10 * CLKS_PER_BIT * CLK_NS + MARGIN_NS;
		table_ready = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int r = 0; r < row_name.size(); r++) begin
			run_row(r);
			print_result(row_name[r]);
		end
		slverr_checks("slverr_access");
		print_result("slverr_access");
		prop_fails = dut_i.props_i.fail_count;
		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, prop_fails);
		if (errors == 0 && prop_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
uart_word_pkg.sv
uart_rx.sv
word_packer.sv
word_fifo.sv
axil_word_regs.sv
uart_word_top.sv
tb_uart_word_props.sv
tb_uart_word.sv

// ==== Bender.yml ====
package:
  name: uart_word

sources:
  - uart_word_pkg.sv
  - uart_rx.sv
  - word_packer.sv
  - word_fifo.sv
  - axil_word_regs.sv
  - uart_word_top.sv
  - target: test
    files:
      - tb_uart_word_props.sv
      - tb_uart_word.sv
